// ==== sched_top.f ====
source/sched_pkg.sv
source/issue_entry.sv
source/issue_queue.sv
source/prf.sv
source/alu_pipe.sv
source/sched_top.sv
test/tb_sched_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_sched_top \
  -f sched_top.f -Mdir obj_dir -o tb_sched_top
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_sched_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// ==== test/tb_sched_top.sv ====
// Testbench for sched_top: dispatches instruction streams and checks each done report against a model
`default_nettype none

module tb_sched_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 300;
  localparam int NTAGS   = 64;

  logic                            i_clk;
  logic                            i_reset_n;
  logic                            i_flush;
  logic                            i_disp_valid;
  sched_pkg::alu_op_e              i_disp_op;
  logic [sched_pkg::REG_W-1:0]     i_disp_rd;
  logic [sched_pkg::REG_W-1:0]     i_disp_rs1;
  logic [sched_pkg::REG_W-1:0]     i_disp_rs2;
  logic [sched_pkg::TAG_W-1:0]     i_disp_tag;
  logic                            i_done_accept;
  logic                            o_disp_ready;
  logic                            o_done_valid;
  logic [sched_pkg::TAG_W-1:0]     o_done_tag;
  logic [sched_pkg::REG_W-1:0]     o_done_rd;
  logic [sched_pkg::DATA_W-1:0]    o_done_data;

  // Model state, written by the stimulus side
  logic [sched_pkg::DATA_W-1:0]    model_reg [sched_pkg::NUM_REGS];
  bit                              reg_known [sched_pkg::NUM_REGS];
  logic [sched_pkg::DATA_W-1:0]    exp_data [NTAGS];
  logic [sched_pkg::REG_W-1:0]     exp_rd [NTAGS];
  logic [sched_pkg::REG_W-1:0]     src1 [NTAGS];
  logic [sched_pkg::REG_W-1:0]     src2 [NTAGS];
  int                              dcount [NTAGS];
  int                              fcount [NTAGS];
  int                              total_disp;
  int                              total_flushed;
  int                              errors;
  logic [sched_pkg::TAG_W-1:0]     next_tag;
  string                           cur_test;
  int                              test_err_base;
  int                              tests_run;
  int                              tests_clean;
  // Written by the comparison process only
  int                              rcount [NTAGS];
  int                              total_rep;
  int                              cmp_errors;

  sched_top dut_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_disp_valid  (i_disp_valid),
    .i_disp_op     (i_disp_op),
    .i_disp_rd     (i_disp_rd),
    .i_disp_rs1    (i_disp_rs1),
    .i_disp_rs2    (i_disp_rs2),
    .i_disp_tag    (i_disp_tag),
    .o_disp_ready  (o_disp_ready),
    .o_done_valid  (o_done_valid),
    .o_done_tag    (o_done_tag),
    .o_done_rd     (o_done_rd),
    .o_done_data   (o_done_data),
    .i_done_accept (i_done_accept)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic [sched_pkg::DATA_W-1:0] ref_alu(
    input sched_pkg::alu_op_e           op,
    input logic [sched_pkg::DATA_W-1:0] a,
    input logic [sched_pkg::DATA_W-1:0] b
  );
    case (op)
      sched_pkg::OP_ADD: return a + b;
      sched_pkg::OP_SUB: return a - b;
      sched_pkg::OP_AND: return a & b;
      default:           return a ^ b;
    endcase
  endfunction

  function automatic bit is_pending(input logic [sched_pkg::TAG_W-1:0] tag);
    return dcount[tag] > rcount[tag] + fcount[tag];
  endfunction

  function automatic int outstanding();
    return total_disp - total_rep - total_flushed;
  endfunction

  // Destination also read or written by an unreported instruction
  function automatic bit reg_in_use(input logic [sched_pkg::REG_W-1:0] r);
    for (int t = 0; t < NTAGS; t++) begin
      if (is_pending(sched_pkg::TAG_W'(t)) && (exp_rd[t] == r || src1[t] == r || src2[t] == r)) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // ----------------------------------------------------------------------
  // Comparison of accepted reports
  // ----------------------------------------------------------------------
  // Report is consumed on the next rising edge
  always @(negedge i_clk) begin
    if (i_reset_n && o_done_valid && i_done_accept) begin
      if (!is_pending(o_done_tag)) begin
        $display("ERROR %s: report for tag %0d, which is flushed, already reported or unknown",
                 cur_test, o_done_tag);
        cmp_errors++;
      end else begin
        if (o_done_rd !== exp_rd[o_done_tag]) begin
          $display("FAIL %s: tag %0d rd expected %0d actual %0d",
                   cur_test, o_done_tag, exp_rd[o_done_tag], o_done_rd);
          cmp_errors++;
        end
        if (o_done_data !== exp_data[o_done_tag]) begin
          $display("FAIL %s: tag %0d data expected %h actual %h",
                   cur_test, o_done_tag, exp_data[o_done_tag], o_done_data);
          cmp_errors++;
        end
        rcount[o_done_tag]++;
        total_rep++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------
  task automatic dispatch(input sched_pkg::alu_op_e op, input logic [sched_pkg::REG_W-1:0] rd,
                          input logic [sched_pkg::REG_W-1:0] rs1,
                          input logic [sched_pkg::REG_W-1:0] rs2);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge i_clk);
    while (reg_in_use(rd) && wait_cnt < TIMEOUT) begin
      @(negedge i_clk);
      wait_cnt++;
    end
    if (wait_cnt >= TIMEOUT) begin
      $display("ERROR %s: register %0d stayed in use, dispatch skipped", cur_test, rd);
      errors++;
      return;
    end
    if (!reg_known[rs1] || !reg_known[rs2]) begin
      $display("ERROR %s: stimulus reads a register with no known value", cur_test);
      errors++;
    end
    @(posedge i_clk);
    i_disp_valid <= 1'b1;
    i_disp_op    <= op;
    i_disp_rd    <= rd;
    i_disp_rs1   <= rs1;
    i_disp_rs2   <= rs2;
    i_disp_tag   <= next_tag;
    wait_cnt = 0;
    @(negedge i_clk);
    while (!o_disp_ready && wait_cnt < TIMEOUT) begin
      @(negedge i_clk);
      wait_cnt++;
    end
    @(posedge i_clk);
    i_disp_valid <= 1'b0;
    if (wait_cnt >= TIMEOUT) begin
      $display("ERROR %s: dispatch of tag %0d was never accepted", cur_test, next_tag);
      errors++;
      return;
    end
    exp_data[next_tag] = ref_alu(op, model_reg[rs1], model_reg[rs2]);
    exp_rd[next_tag]   = rd;
    src1[next_tag]     = rs1;
    src2[next_tag]     = rs2;
    model_reg[rd]      = exp_data[next_tag];
    reg_known[rd]      = 1'b1;
    dcount[next_tag]++;
    total_disp++;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic drain();
    int wait_cnt;
    wait_cnt = 0;
    @(negedge i_clk);
    while (outstanding() != 0 && wait_cnt < TIMEOUT) begin
      @(negedge i_clk);
      wait_cnt++;
    end
    if (wait_cnt >= TIMEOUT) begin
      $display("ERROR %s: %0d reports never arrived", cur_test, outstanding());
      errors++;
    end
  endtask

  // Holds accept low and watches the queue fill and the report stay put
  task automatic hold_reports(input int cycles);
    bit                           held;
    bit                           full_seen;
    logic [sched_pkg::TAG_W-1:0]  h_tag;
    logic [sched_pkg::DATA_W-1:0] h_data;
    held      = 1'b0;
    full_seen = 1'b0;
    h_tag     = '0;
    h_data    = '0;
    @(posedge i_clk);
    i_done_accept <= 1'b0;
    for (int c = 0; c < cycles; c++) begin
      @(negedge i_clk);
      if (outstanding() == sched_pkg::NUM_ENTRIES) begin
        full_seen = 1'b1;
        if (o_disp_ready) begin
          $display("ERROR %s: o_disp_ready high with all entries occupied", cur_test);
          errors++;
        end
      end
      if (held) begin
        if (!o_done_valid || o_done_tag !== h_tag || o_done_data !== h_data) begin
          $display("FAIL %s: held report expected tag %0d data %h actual tag %0d data %h",
                   cur_test, h_tag, h_data, o_done_tag, o_done_data);
          errors++;
        end
      end else if (o_done_valid) begin
        held   = 1'b1;
        h_tag  = o_done_tag;
        h_data = o_done_data;
      end
    end
    if (!full_seen) begin
      $display("ERROR %s: queue never filled while reports were held", cur_test);
      errors++;
    end
    @(posedge i_clk);
    i_done_accept <= 1'b1;
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = errors + cmp_errors;
  endtask

  task automatic end_test();
    int n;
    n = errors + cmp_errors - test_err_base;
    tests_run++;
    if (n == 0) begin
      tests_clean++;
    end
    $display("[%0t] %s finished, %0d error(s)", $time, cur_test, n);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    sched_pkg::alu_op_e           r_op;
    logic [sched_pkg::REG_W-1:0]  r_rd;
    logic [sched_pkg::REG_W-1:0]  r_s1;
    logic [sched_pkg::REG_W-1:0]  r_s2;
    logic [sched_pkg::TAG_W-1:0]  flush_base;
    i_reset_n     = 1'b0;
    i_flush       = 1'b0;
    i_disp_valid  = 1'b0;
    i_disp_op     = sched_pkg::OP_ADD;
    i_disp_rd     = '0;
    i_disp_rs1    = '0;
    i_disp_rs2    = '0;
    i_disp_tag    = '0;
    i_done_accept = 1'b1;
    void'($urandom(67));
    for (int n = 0; n < sched_pkg::NUM_REGS; n++) begin
      model_reg[n] = sched_pkg::DATA_W'(n);
      reg_known[n] = 1'b1;
    end
    for (int t = 0; t < NTAGS; t++) begin
      dcount[t] = 0;
      fcount[t] = 0;
      rcount[t] = 0;
    end
    total_disp    = 0;
    total_flushed = 0;
    total_rep     = 0;
    errors        = 0;
    cmp_errors    = 0;
    tests_run     = 0;
    tests_clean   = 0;
    next_tag      = '0;
    cur_test      = "reset";
    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;

    start_test("opcodes");
    @(negedge i_clk);
    if (!o_disp_ready || o_done_valid) begin
      $display("ERROR %s: wrong ready or done level after reset", cur_test);
      errors++;
    end
    dispatch(sched_pkg::OP_ADD, 4'd8, 4'd0, 4'd1);
    dispatch(sched_pkg::OP_SUB, 4'd9, 4'd2, 4'd3);
    dispatch(sched_pkg::OP_AND, 4'd10, 4'd4, 4'd5);
    dispatch(sched_pkg::OP_XOR, 4'd11, 4'd6, 4'd7);
    drain();
    end_test();

    start_test("dependent_chain");
    r_s1 = 4'd8;
    for (int k = 0; k < 6; k++) begin
      dispatch(sched_pkg::alu_op_e'(2'(k)), 4'(k + 1), r_s1, 4'(k + 10));
      r_s1 = 4'(k + 1);
    end
    drain();
    end_test();

    start_test("random_stream");
    for (int k = 0; k < 40; k++) begin
      r_op = sched_pkg::alu_op_e'(2'($urandom % 4));
      r_rd = 4'($urandom % 16);
      r_s1 = 4'($urandom % 16);
      r_s2 = 4'($urandom % 16);
      dispatch(r_op, r_rd, r_s1, r_s2);
    end
    drain();
    end_test();

    start_test("accept_hold");
    fork
      begin
        for (int k = 0; k < 10; k++) begin
          dispatch(sched_pkg::alu_op_e'(2'(k)), 4'(k + 6), 4'(k % 6), 4'((k + 1) % 6));
        end
      end
      hold_reports(30);
    join
    drain();
    end_test();

    start_test("flush");
    @(posedge i_clk);
    i_done_accept <= 1'b0;
    flush_base = next_tag;
    dispatch(sched_pkg::OP_ADD, 4'd12, 4'd0, 4'd1);
    dispatch(sched_pkg::OP_SUB, 4'd13, 4'd12, 4'd2);
    dispatch(sched_pkg::OP_AND, 4'd14, 4'd13, 4'd3);
    dispatch(sched_pkg::OP_XOR, 4'd15, 4'd14, 4'd0);
    @(posedge i_clk);
    i_flush <= 1'b1;
    @(posedge i_clk);
    i_flush <= 1'b0;
    // Flushed work is forgotten, its targets hold unknown values
    for (int t = 0; t < 4; t++) begin
      fcount[flush_base + 6'(t)]++;
      total_flushed++;
      reg_known[12 + t] = 1'b0;
    end
    @(negedge i_clk);
    if (!o_disp_ready || o_done_valid) begin
      $display("ERROR %s: queue not empty and ready in the cycle after flush", cur_test);
      errors++;
    end
    @(posedge i_clk);
    i_done_accept <= 1'b1;
    for (int k = 0; k < 6; k++) begin
      dispatch(sched_pkg::alu_op_e'(2'(k)), 4'(k + 6), 4'(k), 4'(11 - k));
    end
    drain();
    end_test();

    $display("summary: %0d tests run, %0d clean, %0d reports checked, %0d errors",
             tests_run, tests_clean, total_rep, errors + cmp_errors);
    if (errors + cmp_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/sched_top.sv ====
// Scheduler top level: joins dispatch, issue queue, register file and execute pipe
`default_nettype none

module sched_top (
  input  wire logic                            i_clk,
  input  wire logic                            i_reset_n,
  input  wire logic                            i_flush,
  input  wire logic                            i_disp_valid,
  input  sched_pkg::alu_op_e                   i_disp_op,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rd,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rs1,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rs2,
  input  wire logic [sched_pkg::TAG_W-1:0]     i_disp_tag,
  output logic                                 o_disp_ready,
  output logic                                 o_done_valid,
  output logic [sched_pkg::TAG_W-1:0]          o_done_tag,
  output logic [sched_pkg::REG_W-1:0]          o_done_rd,
  output logic [sched_pkg::DATA_W-1:0]         o_done_data,
  input  wire logic                            i_done_accept
);

  logic                           w_alloc;
  logic                           w_rd_busy;
  logic                           w_rs1_busy;
  logic                           w_rs2_busy;
  logic                           w_issue_valid;
  logic [sched_pkg::ENTRY_W-1:0]  w_issue_idx;
  sched_pkg::alu_op_e             w_issue_op;
  logic [sched_pkg::REG_W-1:0]    w_issue_rd;
  logic [sched_pkg::REG_W-1:0]    w_issue_rs1;
  logic [sched_pkg::REG_W-1:0]    w_issue_rs2;
  logic [sched_pkg::DATA_W-1:0]   w_src_a;
  logic [sched_pkg::DATA_W-1:0]   w_src_b;
  logic                           w_wb_valid;
  logic [sched_pkg::REG_W-1:0]    w_wb_rd;
  logic [sched_pkg::ENTRY_W-1:0]  w_wb_idx;
  logic [sched_pkg::DATA_W-1:0]   w_wb_data;

  issue_queue queue_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_disp_valid  (i_disp_valid),
    .i_disp_op     (i_disp_op),
    .i_disp_rd     (i_disp_rd),
    .i_disp_rs1    (i_disp_rs1),
    .i_disp_rs2    (i_disp_rs2),
    .i_disp_tag    (i_disp_tag),
    .i_rs1_busy    (w_rs1_busy),
    .i_rs2_busy    (w_rs2_busy),
    .i_rd_busy     (w_rd_busy),
    .i_wb_valid    (w_wb_valid),
    .i_wb_rd       (w_wb_rd),
    .i_wb_idx      (w_wb_idx),
    .i_wb_data     (w_wb_data),
    .o_disp_ready  (o_disp_ready),
    .o_alloc       (w_alloc),
    .o_issue_valid (w_issue_valid),
    .o_issue_idx   (w_issue_idx),
    .o_issue_op    (w_issue_op),
    .o_issue_rd    (w_issue_rd),
    .o_issue_rs1   (w_issue_rs1),
    .o_issue_rs2   (w_issue_rs2),
    .o_done_valid  (o_done_valid),
    .o_done_tag    (o_done_tag),
    .o_done_rd     (o_done_rd),
    .o_done_data   (o_done_data),
    .i_done_accept (i_done_accept)
  );

  prf prf_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_flush    (i_flush),
    .i_alloc    (w_alloc),
    .i_disp_rd  (i_disp_rd),
    .i_disp_rs1 (i_disp_rs1),
    .i_disp_rs2 (i_disp_rs2),
    .i_rd_a     (w_issue_rs1),
    .i_rd_b     (w_issue_rs2),
    .i_wb_valid (w_wb_valid),
    .i_wb_rd    (w_wb_rd),
    .i_wb_data  (w_wb_data),
    .o_rd_busy  (w_rd_busy),
    .o_rs1_busy (w_rs1_busy),
    .o_rs2_busy (w_rs2_busy),
    .o_data_a   (w_src_a),
    .o_data_b   (w_src_b)
  );

  alu_pipe pipe_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush       (i_flush),
    .i_issue_valid (w_issue_valid),
    .i_issue_idx   (w_issue_idx),
    .i_issue_op    (w_issue_op),
    .i_issue_rd    (w_issue_rd),
    .i_src_a       (w_src_a),
    .i_src_b       (w_src_b),
    .o_wb_valid    (w_wb_valid),
    .o_wb_rd       (w_wb_rd),
    .o_wb_idx      (w_wb_idx),
    .o_wb_data     (w_wb_data)
  );

endmodule

`default_nettype wire

// ==== source/alu_pipe.sv ====
// Two-stage integer execute pipe: computes at the execute stage and drives writeback and wakeup
`default_nettype none

module alu_pipe (
  input  wire logic                            i_clk,
  input  wire logic                            i_reset_n,
  input  wire logic                            i_flush,
  input  wire logic                            i_issue_valid,
  input  wire logic [sched_pkg::ENTRY_W-1:0]   i_issue_idx,
  input  sched_pkg::alu_op_e                   i_issue_op,
  input  wire logic [sched_pkg::REG_W-1:0]     i_issue_rd,
  input  wire logic [sched_pkg::DATA_W-1:0]    i_src_a,
  input  wire logic [sched_pkg::DATA_W-1:0]    i_src_b,
  output logic                                 o_wb_valid,
  output logic [sched_pkg::REG_W-1:0]          o_wb_rd,
  output logic [sched_pkg::ENTRY_W-1:0]        o_wb_idx,
  output logic [sched_pkg::DATA_W-1:0]         o_wb_data
);

  logic                           r_ex_valid;
  logic [sched_pkg::ENTRY_W-1:0]  r_ex_idx;
  logic [sched_pkg::REG_W-1:0]    r_ex_rd;
  logic [sched_pkg::DATA_W-1:0]   r_ex_data;
  logic                           r_wb_valid;
  logic [sched_pkg::ENTRY_W-1:0]  r_wb_idx;
  logic [sched_pkg::REG_W-1:0]    r_wb_rd;
  logic [sched_pkg::DATA_W-1:0]   r_wb_data;

  // ----------------------------------------------------------------------
  // Valid bits
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex_valid <= 1'b0;
      r_wb_valid <= 1'b0;
    end else if (i_flush) begin
      r_ex_valid <= 1'b0;
      r_wb_valid <= 1'b0;
    end else begin
      r_ex_valid <= i_issue_valid;
      r_wb_valid <= r_ex_valid;
    end
  end

  // Execute then writeback payload
  always_ff @(posedge i_clk) begin
    r_ex_idx  <= i_issue_idx;
    r_ex_rd   <= i_issue_rd;
    r_ex_data <= sched_pkg::alu_result(i_issue_op, i_src_a, i_src_b);
    r_wb_idx  <= r_ex_idx;
    r_wb_rd   <= r_ex_rd;
    r_wb_data <= r_ex_data;
  end

  assign o_wb_valid = r_wb_valid;
  assign o_wb_rd    = r_wb_rd;
  assign o_wb_idx   = r_wb_idx;
  assign o_wb_data  = r_wb_data;

endmodule

`default_nettype wire

// ==== source/prf.sv ====
// Physical register file with busy tracking; answers dispatch checks and feeds the ALU operands
`default_nettype none

module prf (
  input  wire logic                            i_clk,
  input  wire logic                            i_reset_n,
  input  wire logic                            i_flush,
  input  wire logic                            i_alloc,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rd,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rs1,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rs2,
  input  wire logic [sched_pkg::REG_W-1:0]     i_rd_a,
  input  wire logic [sched_pkg::REG_W-1:0]     i_rd_b,
  input  wire logic                            i_wb_valid,
  input  wire logic [sched_pkg::REG_W-1:0]     i_wb_rd,
  input  wire logic [sched_pkg::DATA_W-1:0]    i_wb_data,
  output logic                                 o_rd_busy,
  output logic                                 o_rs1_busy,
  output logic                                 o_rs2_busy,
  output logic [sched_pkg::DATA_W-1:0]         o_data_a,
  output logic [sched_pkg::DATA_W-1:0]         o_data_b
);

  logic [sched_pkg::DATA_W-1:0]   r_data [sched_pkg::NUM_REGS];
  logic [sched_pkg::NUM_REGS-1:0] r_busy;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int n = 0; n < sched_pkg::NUM_REGS; n++) begin
        r_data[n] <= sched_pkg::DATA_W'(n);
      end
      r_busy <= '0;
    end else if (i_flush) begin
      // In-flight writeback is dropped with the flush
      r_busy <= '0;
    end else begin
      if (i_wb_valid) begin
        r_data[i_wb_rd] <= i_wb_data;
        r_busy[i_wb_rd] <= 1'b0;
      end
      if (i_alloc) begin
        r_busy[i_disp_rd] <= 1'b1;
      end
    end
  end

  // Same-cycle writeback already counts as ready
  assign o_rs1_busy = r_busy[i_disp_rs1] & ~(i_wb_valid & (i_wb_rd == i_disp_rs1));
  assign o_rs2_busy = r_busy[i_disp_rs2] & ~(i_wb_valid & (i_wb_rd == i_disp_rs2));
  assign o_rd_busy  = r_busy[i_disp_rd];

  assign o_data_a   = r_data[i_rd_a];
  assign o_data_b   = r_data[i_rd_b];

endmodule

`default_nettype wire

// ==== source/issue_queue.sv ====
// Issue queue: allocates slots, picks ready entries for the pipe and selects done reports
`default_nettype none

module issue_queue (
  input  wire logic                            i_clk,
  input  wire logic                            i_reset_n,
  input  wire logic                            i_flush,
  input  wire logic                            i_disp_valid,
  input  sched_pkg::alu_op_e                   i_disp_op,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rd,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rs1,
  input  wire logic [sched_pkg::REG_W-1:0]     i_disp_rs2,
  input  wire logic [sched_pkg::TAG_W-1:0]     i_disp_tag,
  input  wire logic                            i_rs1_busy,
  input  wire logic                            i_rs2_busy,
  input  wire logic                            i_rd_busy,
  input  wire logic                            i_wb_valid,
  input  wire logic [sched_pkg::REG_W-1:0]     i_wb_rd,
  input  wire logic [sched_pkg::ENTRY_W-1:0]   i_wb_idx,
  input  wire logic [sched_pkg::DATA_W-1:0]    i_wb_data,
  output logic                                 o_disp_ready,
  output logic                                 o_alloc,
  output logic                                 o_issue_valid,
  output logic [sched_pkg::ENTRY_W-1:0]        o_issue_idx,
  output sched_pkg::alu_op_e                   o_issue_op,
  output logic [sched_pkg::REG_W-1:0]          o_issue_rd,
  output logic [sched_pkg::REG_W-1:0]          o_issue_rs1,
  output logic [sched_pkg::REG_W-1:0]          o_issue_rs2,
  output logic                                 o_done_valid,
  output logic [sched_pkg::TAG_W-1:0]          o_done_tag,
  output logic [sched_pkg::REG_W-1:0]          o_done_rd,
  output logic [sched_pkg::DATA_W-1:0]         o_done_data,
  input  wire logic                            i_done_accept
);

  logic [sched_pkg::NUM_ENTRIES-1:0] w_free;
  logic [sched_pkg::NUM_ENTRIES-1:0] w_ready;
  logic [sched_pkg::NUM_ENTRIES-1:0] w_done;
  logic [sched_pkg::ENTRY_W-1:0]     w_alloc_idx;
  logic [sched_pkg::ENTRY_W-1:0]     w_done_idx;
  sched_pkg::alu_op_e                w_op   [sched_pkg::NUM_ENTRIES];
  logic [sched_pkg::REG_W-1:0]       w_rd   [sched_pkg::NUM_ENTRIES];
  logic [sched_pkg::REG_W-1:0]       w_rs1  [sched_pkg::NUM_ENTRIES];
  logic [sched_pkg::REG_W-1:0]       w_rs2  [sched_pkg::NUM_ENTRIES];
  logic [sched_pkg::TAG_W-1:0]       w_tag  [sched_pkg::NUM_ENTRIES];
  logic [sched_pkg::DATA_W-1:0]      w_data [sched_pkg::NUM_ENTRIES];

  // Lowest set bit wins
  function automatic logic [sched_pkg::ENTRY_W-1:0] lowest_idx(
    input logic [sched_pkg::NUM_ENTRIES-1:0] vec
  );
    logic [sched_pkg::ENTRY_W-1:0] idx;
    idx = '0;
    for (int k = sched_pkg::NUM_ENTRIES - 1; k >= 0; k--) begin
      if (vec[k]) begin
        idx = sched_pkg::ENTRY_W'(k);
      end
    end
    return idx;
  endfunction

  assign w_alloc_idx   = lowest_idx(w_free);
  assign o_issue_idx   = lowest_idx(w_ready);
  assign w_done_idx    = lowest_idx(w_done);

  assign o_disp_ready  = (|w_free) & ~i_rd_busy & ~i_flush;
  assign o_alloc       = i_disp_valid & o_disp_ready;

  assign o_issue_valid = |w_ready;
  assign o_issue_op    = w_op[o_issue_idx];
  assign o_issue_rd    = w_rd[o_issue_idx];
  assign o_issue_rs1   = w_rs1[o_issue_idx];
  assign o_issue_rs2   = w_rs2[o_issue_idx];

  assign o_done_valid  = |w_done;
  assign o_done_tag    = w_tag[w_done_idx];
  assign o_done_rd     = w_rd[w_done_idx];
  assign o_done_data   = w_data[w_done_idx];

  // ----------------------------------------------------------------------
  // Entry array
  // ----------------------------------------------------------------------
  for (genvar k = 0; k < sched_pkg::NUM_ENTRIES; k++) begin : g_entry
    issue_entry entry_i (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_put         (o_alloc & (w_alloc_idx == sched_pkg::ENTRY_W'(k))),
      .i_flush       (i_flush),
      .i_op          (i_disp_op),
      .i_rd          (i_disp_rd),
      .i_rs1         (i_disp_rs1),
      .i_rs2         (i_disp_rs2),
      .i_tag         (i_disp_tag),
      .i_rs1_ready   (~i_rs1_busy),
      .i_rs2_ready   (~i_rs2_busy),
      .i_wb_valid    (i_wb_valid),
      .i_wb_rd       (i_wb_rd),
      .i_pipe_done   (i_wb_valid & (i_wb_idx == sched_pkg::ENTRY_W'(k))),
      .i_pipe_data   (i_wb_data),
      .i_picked      (o_issue_valid & (o_issue_idx == sched_pkg::ENTRY_W'(k))),
      .i_done_accept (i_done_accept & o_done_valid & (w_done_idx == sched_pkg::ENTRY_W'(k))),
      .o_free        (w_free[k]),
      .o_ready       (w_ready[k]),
      .o_op          (w_op[k]),
      .o_rd          (w_rd[k]),
      .o_rs1         (w_rs1[k]),
      .o_rs2         (w_rs2[k]),
      .o_done_valid  (w_done[k]),
      .o_tag         (w_tag[k]),
      .o_data        (w_data[k])
    );
  end

endmodule

`default_nettype wire

// ==== source/issue_entry.sv ====
// One scheduler slot: holds a dispatched instruction until it issues, completes and reports
`default_nettype none

module issue_entry (
  input  wire logic                            i_clk,
  input  wire logic                            i_reset_n,
  input  wire logic                            i_put,
  input  wire logic                            i_flush,
  input  sched_pkg::alu_op_e                   i_op,
  input  wire logic [sched_pkg::REG_W-1:0]     i_rd,
  input  wire logic [sched_pkg::REG_W-1:0]     i_rs1,
  input  wire logic [sched_pkg::REG_W-1:0]     i_rs2,
  input  wire logic [sched_pkg::TAG_W-1:0]     i_tag,
  input  wire logic                            i_rs1_ready,
  input  wire logic                            i_rs2_ready,
  input  wire logic                            i_wb_valid,
  input  wire logic [sched_pkg::REG_W-1:0]     i_wb_rd,
  input  wire logic                            i_pipe_done,
  input  wire logic [sched_pkg::DATA_W-1:0]    i_pipe_data,
  input  wire logic                            i_picked,
  input  wire logic                            i_done_accept,
  output logic                                 o_free,
  output logic                                 o_ready,
  output sched_pkg::alu_op_e                   o_op,
  output logic [sched_pkg::REG_W-1:0]          o_rd,
  output logic [sched_pkg::REG_W-1:0]          o_rs1,
  output logic [sched_pkg::REG_W-1:0]          o_rs2,
  output logic                                 o_done_valid,
  output logic [sched_pkg::TAG_W-1:0]          o_tag,
  output logic [sched_pkg::DATA_W-1:0]         o_data
);

  sched_pkg::entry_state_e          r_state;
  logic                             r_rs1_rdy;
  logic                             r_rs2_rdy;
  sched_pkg::alu_op_e               r_op;
  logic [sched_pkg::REG_W-1:0]      r_rd;
  logic [sched_pkg::REG_W-1:0]      r_rs1;
  logic [sched_pkg::REG_W-1:0]      r_rs2;
  logic [sched_pkg::TAG_W-1:0]      r_tag;
  logic [sched_pkg::DATA_W-1:0]     r_data;

  // ----------------------------------------------------------------------
  // State machine and operand wakeup
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state   <= sched_pkg::ST_FREE;
      r_rs1_rdy <= 1'b0;
      r_rs2_rdy <= 1'b0;
    end else if (i_flush) begin
      r_state <= sched_pkg::ST_FREE;
    end else begin
      case (r_state)
        sched_pkg::ST_FREE: begin
          if (i_put) begin
            r_state <= sched_pkg::ST_WAIT;
          end
        end
        sched_pkg::ST_WAIT: begin
          if (i_picked) begin
            r_state <= sched_pkg::ST_ISSUED;
          end
        end
        sched_pkg::ST_ISSUED: begin
          if (i_pipe_done) begin
            r_state <= sched_pkg::ST_DONE;
          end
        end
        default: begin
          if (i_done_accept) begin
            r_state <= sched_pkg::ST_FREE;
          end
        end
      endcase

      if (i_put) begin
        r_rs1_rdy <= i_rs1_ready;
        r_rs2_rdy <= i_rs2_ready;
      end else begin
        // Writeback of a source register wakes it
        r_rs1_rdy <= r_rs1_rdy | (i_wb_valid & (i_wb_rd == r_rs1));
        r_rs2_rdy <= r_rs2_rdy | (i_wb_valid & (i_wb_rd == r_rs2));
      end
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (i_put) begin
      r_op  <= i_op;
      r_rd  <= i_rd;
      r_rs1 <= i_rs1;
      r_rs2 <= i_rs2;
      r_tag <= i_tag;
    end
    if (i_pipe_done) begin
      r_data <= i_pipe_data;
    end
  end

  assign o_free       = (r_state == sched_pkg::ST_FREE);
  assign o_ready      = (r_state == sched_pkg::ST_WAIT) & r_rs1_rdy & r_rs2_rdy;
  assign o_done_valid = (r_state == sched_pkg::ST_DONE);
  assign o_op         = r_op;
  assign o_rd         = r_rd;
  assign o_rs1        = r_rs1;
  assign o_rs2        = r_rs2;
  assign o_tag        = r_tag;
  assign o_data       = r_data;

endmodule

`default_nettype wire

// ==== source/sched_pkg.sv ====
// Shared sizes, opcode and entry-state encodings, and the ALU result rule for the scheduler
`default_nettype none

package sched_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int NUM_REGS    = 16;
  localparam int REG_W       = 4;
  localparam int DATA_W      = 16;
  localparam int NUM_ENTRIES = 8;
  localparam int ENTRY_W     = 3;
  localparam int TAG_W       = 6;

  // ----------------------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_AND = 2'd2,
    OP_XOR = 2'd3
  } alu_op_e;

  // Life of one queue slot
  typedef enum logic [1:0] {
    ST_FREE   = 2'd0,
    ST_WAIT   = 2'd1,
    ST_ISSUED = 2'd2,
    ST_DONE   = 2'd3
  } entry_state_e;

  // ----------------------------------------------------------------------
  // Execute rule
  // ----------------------------------------------------------------------
  function automatic logic [DATA_W-1:0] alu_result(
    input alu_op_e           op,
    input logic [DATA_W-1:0] a,
    input logic [DATA_W-1:0] b
  );
    logic [DATA_W-1:0] res;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      default: res = a ^ b;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire
